// File: src.f
+incdir+source
source/pi1q_pkg.sv
source/pi1q_dram.sv
source/pi1q.sv
source/pi1q_mem_slave.sv
source/pi1q_subsys.sv
verification/tb_clkgen.sv
verification/pi1q_sva.sv
verification/pi1q_tb.sv

// File: Bender.yml
package:
  name: pi1q

sources:
  - include_dirs:
      - source
    files:
      - source/pi1q_pkg.sv
      - source/pi1q_dram.sv
      - source/pi1q.sv
      - source/pi1q_mem_slave.sv
      - source/pi1q_subsys.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_clkgen.sv
      - verification/pi1q_sva.sv
      - verification/pi1q_tb.sv

// File: verification/pi1q_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pi1q_params.svh"

// testbench for the memory subsystem
// every master runs a random script and a model memory replays the accepted
// requests in ready-edge order, which is the order the slave sees them in
module pi1q_tb import pi1q_pkg::*; ();

	localparam int M = `PI1Q_MASTERCOUNT;
	localparam int N_OPS = 40;
	// master 0 runs this many extra ops alone once all scripts are done
	localparam int SOLO_OPS = 16;
	localparam int TOTAL_OPS = N_OPS + SOLO_OPS;
	// a narrow window of words makes the masters overwrite each other often
	localparam int ADDR_WORDS = 16;
	localparam int FAIR_BOUND = M * (`PI1Q_SLAVE_WAIT + 3);
	localparam int SOLO_SETTLE = 4;
	localparam int WDOG_CYCLES = TOTAL_OPS * M * (`PI1Q_SLAVE_WAIT + M + 4) + 10;

	logic clk;
	logic rst;
	pi1q_req_t [M-1:0] m_req;
	pi1q_data_t [M-1:0] m_data;
	logic [M-1:0] m_rdy;

	integer seed;
	int err_cnt;
	int chk_cnt;
	int solo_edges;
	logic phase2;
	pi1q_req_t script_q [M][TOTAL_OPS];
	pi1q_data_t model_mem [2 ** `PI1Q_MEMDEPTH_LOG2];
	int done_cnt [M];
	int gap [M];
	logic gap_valid [M];
	logic rd_pending [M];
	pi1q_data_t rd_expect [M];

	tb_clkgen u_clkgen (
		.clk_o(clk),
		.rst_o(rst)
	);

	pi1q_subsys u_pi1q_subsys (
		.m_clk_i (clk),
		.rst_i   (rst),
		.m_req_i (m_req),
		.m_data_o(m_data),
		.m_rdy_o (m_rdy)
	);

	// applies one op to the model and hands back the word as it was before
	function automatic pi1q_data_t ref_access(input pi1q_req_t req);
		pi1q_data_t old_word;
		int idx;
		idx = req.addr[`PI1Q_MEMDEPTH_LOG2-1:0];
		old_word = model_mem[idx];
		if (req.op == PI_WROP || req.op == PI_RWOP) begin
			for (int b = 0; b < $bits(pi1q_sel_t); b++) begin
				if (req.sel[b]) begin
					model_mem[idx][b*8 +: 8] = req.data[b*8 +: 8];
				end
			end
		end
		return old_word;
	endfunction

	task automatic check_val(input string name, input pi1q_data_t exp_v, input pi1q_data_t act_v);
		chk_cnt++;
		if (act_v !== exp_v) begin
			err_cnt++;
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
		end
	endtask

	function automatic int masters_finished();
		int cnt;
		cnt = 0;
		for (int m = 0; m < M; m++) begin
			if (done_cnt[m] >= N_OPS) begin
				cnt++;
			end
		end
		return cnt;
	endfunction

	task automatic init_run();
		pi1q_req_t req;
		seed = 32'h9d91;
		err_cnt = 0;
		chk_cnt = 0;
		solo_edges = 0;
		phase2 = 1'b0;
		for (int w = 0; w < $size(model_mem); w++) begin
			model_mem[w] = '0;
		end
		for (int m = 0; m < M; m++) begin
			// an all-zero request is an idle one
			m_req[m] = '0;
			done_cnt[m] = 0;
			gap[m] = 0;
			gap_valid[m] = 1'b0;
			rd_pending[m] = 1'b0;
			rd_expect[m] = '0;
			for (int i = 0; i < TOTAL_OPS; i++) begin
				req.op = pi1q_op_t'($unsigned($random(seed)) % 3 + 1);
				req.addr = pi1q_addr_t'($unsigned($random(seed)) % ADDR_WORDS);
				req.data = $random(seed);
				req.sel = ($random(seed) & 1) ? '1 : pi1q_sel_t'($random(seed));
				// a closing write lets the read before it be checked at its edge
				if (i == N_OPS - 1 || i == TOTAL_OPS - 1) begin
					req.op = PI_WROP;
				end
				script_q[m][i] = req;
			end
		end
	endtask

	// a master holds its op until a ready edge takes it and idles after its script
	task automatic drive_requests();
		int limit;
		if (masters_finished() == M) begin
			phase2 = 1'b1;
		end
		for (int m = 0; m < M; m++) begin
			limit = (m == 0 && phase2) ? TOTAL_OPS : N_OPS;
			if (done_cnt[m] < limit) begin
				m_req[m] = script_q[m][done_cnt[m]];
			end else begin
				m_req[m] = '0;
			end
		end
	endtask

	task automatic ready_edge(input int m);
		logic busy;
		busy = (masters_finished() == 0);
		// read data of the previous op is due on this edge
		if (rd_pending[m]) begin
			check_val($sformatf("m_data_o[%0d]", m), rd_expect[m], m_data[m]);
		end
		rd_pending[m] = 1'b0;
		if (m_req[m].op != PI_NOOP) begin
			rd_expect[m] = ref_access(m_req[m]);
			rd_pending[m] = (m_req[m].op == PI_RDOP) || (m_req[m].op == PI_RWOP);
			done_cnt[m]++;
		end
		if (busy && gap_valid[m] && gap[m] > FAIR_BOUND) begin
			err_cnt++;
			$display("at %0t master %0d waited %0d cycles for ready, more than %0d",
				$time, m, gap[m], FAIR_BOUND);
		end
		gap[m] = 0;
		gap_valid[m] = busy;
		if (phase2 && m == 0) begin
			solo_edges++;
		end
		// with master 0 alone the rotation limit settles at 1
		if (phase2 && m >= 2 && solo_edges >= SOLO_SETTLE) begin
			err_cnt++;
			$display("at %0t idle master %0d got a ready edge while master 0 ran alone",
				$time, m);
		end
	endtask

	initial begin
		init_run();
		@(negedge rst);
		forever begin
			drive_requests();
			@(negedge clk);
		end
	end

	// outputs come from registers and are read at the rising edge that samples the request
	always @(posedge clk) begin
		if (!rst) begin
			if ($countones(m_rdy) > 1) begin
				err_cnt++;
				$display("at %0t more than one master is ready", $time);
			end
			for (int m = 0; m < M; m++) begin
				gap[m]++;
				if (m_rdy[m]) begin
					ready_edge(m);
				end
			end
		end
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles, %0d errors so far",
			WDOG_CYCLES, err_cnt);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		@(negedge rst);
		while (done_cnt[0] < TOTAL_OPS) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		if (chk_cnt == 0) begin
			err_cnt++;
			$display("no read data was checked during the run");
		end
		$display("summary: %0d read checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/pi1q_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "pi1q_params.svh"

// protocol checks on the request queue, bound into every pi1q instance
module pi1q_sva import pi1q_pkg::*; (
	input wire                                  m_clk_i,
	input wire                                  rst_i,
	input wire pi1q_req_t [`PI1Q_MASTERCOUNT-1:0] m_req_i,
	input wire [`PI1Q_MASTERCOUNT-1:0]            m_rdy_i,
	input wire pi1q_req_t                         s_req_i,
	input wire                                    s_rdy_i
);

	// loose bound that also covers a change of the rotation limit
	localparam int GRANT_BOUND = 4 * `PI1Q_MASTERCOUNT * (`PI1Q_SLAVE_WAIT + 4);

	// the write side points at one master at a time
	a_one_ready: assert property (@(posedge m_clk_i) disable iff (rst_i)
		$onehot0(m_rdy_i))
		else $error("more than one master ready in one cycle");

	// out of reset the queue is empty, the slave is ready and only master 0 may be granted
	a_reset_state: assert property (@(posedge m_clk_i)
		$fell(rst_i) |-> (s_req_i.op == PI_NOOP) && s_rdy_i && ((m_rdy_i >> 1) == '0))
		else $error("queue does not start empty after reset");

	// a stalled slave must see the same head request until it takes it
	a_hold_head: assert property (@(posedge m_clk_i) disable iff (rst_i)
		(!s_rdy_i && s_req_i.op != PI_NOOP) |=> $stable(s_req_i))
		else $error("head request changed while the slave was busy");

	// a master with a real op waiting is granted within a bounded time
	for (genvar g = 0; g < `PI1Q_MASTERCOUNT; g++) begin : g_grant
		a_grant: assert property (@(posedge m_clk_i) disable iff (rst_i)
			(m_req_i[g].op != PI_NOOP) |-> ##[0:GRANT_BOUND] m_rdy_i[g])
			else $error("master %0d was never granted", g);
	end

endmodule

bind pi1q pi1q_sva u_pi1q_sva (
	.m_clk_i(m_clk_i),
	.rst_i  (rst_i),
	.m_req_i(m_req_i),
	.m_rdy_i(m_rdy_o),
	.s_req_i(s_req_o),
	.s_rdy_i(s_rdy_i)
);

`default_nettype wire

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock with a 10 ns period and a reset held over the first rising edges
module tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	localparam int RST_CYCLES = 10;

	initial begin
		clk_o = 1'b0;
		forever begin
			#5 clk_o = ~clk_o;
		end
	end

	// reset drops on a falling edge so the first rising edge out of reset sees it settled
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: source/pi1q_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "pi1q_params.svh"

// memory subsystem, several masters sharing one RAM slave through the queue
module pi1q_subsys import pi1q_pkg::*; (
	input  wire                                  m_clk_i,
	input  wire                                  rst_i,
	input  wire pi1q_req_t [`PI1Q_MASTERCOUNT-1:0] m_req_i,
	output pi1q_data_t [`PI1Q_MASTERCOUNT-1:0]     m_data_o,
	output logic [`PI1Q_MASTERCOUNT-1:0]           m_rdy_o
);

	// slave side bus between the queue and the RAM
	pi1q_req_t s_req;
	pi1q_data_t s_data;
	logic s_rdy;

	pi1q u_pi1q (
		.m_clk_i (m_clk_i),
		.rst_i   (rst_i),
		.m_req_i (m_req_i),
		.m_data_o(m_data_o),
		.m_rdy_o (m_rdy_o),
		.s_req_o (s_req),
		.s_data_i(s_data),
		.s_rdy_i (s_rdy)
	);

	// the slave shares the master clock, its ready level is the only back-pressure
	pi1q_mem_slave u_mem_slave (
		.m_clk_i (m_clk_i),
		.rst_i   (rst_i),
		.s_req_i (s_req),
		.s_data_o(s_data),
		.s_rdy_o (s_rdy)
	);

endmodule

`default_nettype wire

// File: source/pi1q_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "pi1q_params.svh"

// memory slave behind the request queue
// byte-selectable RAM that stalls the queue with wait states after each access
module pi1q_mem_slave import pi1q_pkg::*; (
	input  wire            m_clk_i,
	input  wire            rst_i,
	input  wire pi1q_req_t s_req_i,
	output pi1q_data_t     s_data_o,
	output logic           s_rdy_o
);

	// word index inside the RAM, upper address bits are not decoded
	typedef logic [`PI1Q_MEMDEPTH_LOG2-1:0] mem_idx_t;

	// counter wide enough to hold the wait count, at least one bit
	localparam int unsigned WAIT_W = $clog2(`PI1Q_SLAVE_WAIT + 2);
	localparam int unsigned SEL_W = $bits(pi1q_sel_t);

	pi1q_data_t mem_q [2 ** `PI1Q_MEMDEPTH_LOG2];
	pi1q_data_t rdata_q;
	mem_idx_t word_idx;
	logic [WAIT_W-1:0] wait_q;
	logic accept;
	logic do_write;

	assign word_idx = s_req_i.addr[`PI1Q_MEMDEPTH_LOG2-1:0];

	// an idle op is never taken, even when the slave is ready
	assign accept = s_rdy_o && (s_req_i.op != PI_NOOP);
	assign do_write = (s_req_i.op == PI_WROP) || (s_req_i.op == PI_RWOP);

	// ready whenever no wait state is counting down
	assign s_rdy_o = (wait_q == '0);

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			wait_q <= '0;
		end else if (accept) begin
			wait_q <= WAIT_W'(`PI1Q_SLAVE_WAIT);
		end else if (wait_q != '0) begin
			wait_q <= wait_q - 1'b1;
		end
	end

	// the RAM comes out of reset holding zeros
	// writes only touch the byte lanes whose select bit is set
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			for (int w = 0; w < 2 ** `PI1Q_MEMDEPTH_LOG2; w++) begin
				mem_q[w] <= '0;
			end
		end else if (accept && do_write) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (s_req_i.sel[b]) begin
					mem_q[word_idx][b*8 +: 8] <= s_req_i.data[b*8 +: 8];
				end
			end
		end
	end

	// every accepted op registers the word as it was before the access,
	// so a swap hands back the old contents
	// the value holds until the next accepted op
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			rdata_q <= '0;
		end else if (accept) begin
			rdata_q <= mem_q[word_idx];
		end
	end

	assign s_data_o = rdata_q;

endmodule

`default_nettype wire

// File: source/pi1q.sv
`timescale 1ns/1ps
`default_nettype none

`include "pi1q_params.svh"

// isolating request queue between several bus masters and one memory slave
// every master owns one queue slot, the slot whose index equals its own number
// the write side visits the masters in turn and the slave side issues the
// slots in the same order, so requests reach the slave in the order of the
// ready edges that accepted them
module pi1q import pi1q_pkg::*; (
	input  wire                                  m_clk_i,
	input  wire                                  rst_i,
	input  wire pi1q_req_t [`PI1Q_MASTERCOUNT-1:0] m_req_i,
	output pi1q_data_t [`PI1Q_MASTERCOUNT-1:0]     m_data_o,
	output logic [`PI1Q_MASTERCOUNT-1:0]           m_rdy_o,
	output pi1q_req_t                              s_req_o,
	input  wire pi1q_data_t                        s_data_i,
	input  wire                                    s_rdy_i
);

	// queue pointers carry one extra bit above the slot index so that
	// a full queue and an empty queue can be told apart
	typedef logic [$bits(pi1q_midx_t):0] qptr_t;

	localparam qptr_t QP_COUNT = qptr_t'(`PI1Q_MASTERCOUNT);
	localparam qptr_t QP_ALMOST = qptr_t'(`PI1Q_MASTERCOUNT - 1);
	// distance of one full lap of the index, a power of two
	localparam qptr_t QP_SPAN = qptr_t'(1 << $bits(pi1q_midx_t));
	localparam pi1q_midx_t IDX_LAST = pi1q_midx_t'(`PI1Q_MASTERCOUNT - 1);

	qptr_t rd_ptr_q;
	qptr_t wr_ptr_q;
	qptr_t q_usage;
	qptr_t span_less_hi;
	qptr_t skip_hold_q;

	pi1q_midx_t rd_idx;
	pi1q_midx_t wr_idx;
	pi1q_midx_t prev_rd_idx_q;
	pi1q_midx_t mstr_hi_q;
	pi1q_midx_t slv_hi_q;
	pi1q_midx_t hi_next_q;
	pi1q_midx_t scan_idx_q;

	logic q_not_empty;
	logic q_not_full;
	logic q_not_almost_full;
	logic pending_rd;
	logic grant_ok;
	logic q_we;
	logic issue_en;
	logic scan_hit;

	pi1q_op_t s_op_prev_q;
	pi1q_req_t head_req;
	pi1q_req_t wr_entry;
	pi1q_data_t [`PI1Q_MASTERCOUNT-1:0] ret_q;

	assign rd_idx = rd_ptr_q[$bits(pi1q_midx_t)-1:0];
	assign wr_idx = wr_ptr_q[$bits(pi1q_midx_t)-1:0];

	// number of slots written and not yet issued
	assign q_usage = wr_ptr_q - rd_ptr_q;
	assign q_not_empty = |q_usage;
	assign q_not_full = (q_usage < QP_COUNT);

	// with one slot left, that slot may still be waiting for its read data,
	// which only gets captured at the next issue, so it must not be reused
	assign q_not_almost_full = (q_usage < QP_ALMOST);
	assign pending_rd = (wr_entry.op == PI_RDOP) || (wr_entry.op == PI_RWOP);

	// no new request is taken while the slave side still runs on an older limit
	assign grant_ok = (mstr_hi_q == slv_hi_q) && q_not_full &&
		(q_not_almost_full || !pending_rd);

	// only the master under the write pointer can be ready
	always_comb begin
		for (int m = 0; m < `PI1Q_MASTERCOUNT; m++) begin
			m_rdy_o[m] = (wr_idx == pi1q_midx_t'(m)) && grant_ok;
		end
	end

	assign q_we = |m_rdy_o;

	pi1q_dram u_queue_ram (
		.m_clk_i (m_clk_i),
		.we_i    (q_we),
		.waddr_i (wr_idx),
		.wdata_i (m_req_i[wr_idx]),
		.raddr_i (rd_idx),
		.rdata_o (head_req),
		.wrdata_o(wr_entry)
	);

	// the slave sees the head entry, an empty queue shows as an idle op
	always_comb begin
		s_req_o = head_req;
		if (!q_not_empty) begin
			s_req_o.op = PI_NOOP;
		end
	end

	// advance when the slave can take the head, or when both this entry and
	// the last one issued are idle, since the slave ignores idle ops anyway
	assign issue_en = (s_rdy_i || (s_op_prev_q == PI_NOOP && s_req_o.op == PI_NOOP)) &&
		q_not_empty;

	// scan the masters from the top down, one per cycle, for the highest one
	// presenting a real op; that becomes the rotation limit of a later round
	assign scan_hit = (m_req_i[scan_idx_q].op != PI_NOOP);

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			hi_next_q <= IDX_LAST;
			scan_idx_q <= IDX_LAST;
		end else if (scan_idx_q == '0 || scan_hit) begin
			// the limit never drops below 1 so the rotation always has two stops
			if (scan_hit) begin
				hi_next_q <= (scan_idx_q > '0) ? scan_idx_q : pi1q_midx_t'(1);
			end
			scan_idx_q <= IDX_LAST;
		end else begin
			scan_idx_q <= scan_idx_q - pi1q_midx_t'(1);
		end
	end

	// step that carries the write pointer from the limit to slot 0 of the next lap
	assign span_less_hi = QP_SPAN - qptr_t'(mstr_hi_q);

	// write side
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			mstr_hi_q <= IDX_LAST;
			skip_hold_q <= QP_SPAN - qptr_t'(IDX_LAST);
		end else if (q_we) begin
			if (wr_idx < mstr_hi_q) begin
				wr_ptr_q <= wr_ptr_q + qptr_t'(1);
			end else begin
				// end of a lap, jump over the idle masters above the limit
				// and keep the jump for the slave side to repeat
				skip_hold_q <= span_less_hi;
				wr_ptr_q <= wr_ptr_q + span_less_hi;
				mstr_hi_q <= hi_next_q;
			end
		end
	end

	// slave side, it follows the write side limit one lap later
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			rd_ptr_q <= '0;
			slv_hi_q <= IDX_LAST;
			prev_rd_idx_q <= '0;
			s_op_prev_q <= PI_NOOP;
			ret_q <= '0;
		end else if (issue_en) begin
			s_op_prev_q <= s_req_o.op;
			// the slave's data belongs to the entry issued before this one
			ret_q[prev_rd_idx_q] <= s_data_i;
			prev_rd_idx_q <= rd_idx;
			if (rd_idx < slv_hi_q) begin
				rd_ptr_q <= rd_ptr_q + qptr_t'(1);
			end else begin
				rd_ptr_q <= rd_ptr_q + skip_hold_q;
				slv_hi_q <= mstr_hi_q;
			end
		end
	end

	// a master picks its data up at its next ready edge
	assign m_data_o = ret_q;

endmodule

`default_nettype wire

// File: source/pi1q_dram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pi1q_params.svh"

// storage for the request queue, one request per master
// one synchronous write port and two asynchronous read ports
module pi1q_dram import pi1q_pkg::*; (
	input  wire             m_clk_i,
	input  wire             we_i,
	input  wire pi1q_midx_t waddr_i,
	input  wire pi1q_req_t  wdata_i,
	input  wire pi1q_midx_t raddr_i,
	output pi1q_req_t       rdata_o,
	output pi1q_req_t       wrdata_o
);

	// each entry is only ever used by the master with the same index
	pi1q_req_t mem_q [`PI1Q_MASTERCOUNT];

	// the write lands at the clock edge where the owning master is ready
	always_ff @(posedge m_clk_i) begin
		if (we_i) begin
			mem_q[waddr_i] <= wdata_i;
		end
	end

	// head of the queue, this is what the slave side issues
	assign rdata_o = mem_q[raddr_i];

	// entry sitting under the write pointer
	// its op shows whether the slave still owes read data for it
	assign wrdata_o = mem_q[waddr_i];

endmodule

`default_nettype wire

// File: source/pi1q_pkg.sv
`default_nettype none

// types shared by the request queue, the memory slave and the top level
package pi1q_pkg;

	`include "pi1q_params.svh"

	// operation code carried with every request
	typedef logic [1:0] pi1q_op_t;

	// bit 1 of the op code marks an operation that returns read data
	localparam pi1q_op_t PI_NOOP = 2'b00;
	localparam pi1q_op_t PI_WROP = 2'b01;
	localparam pi1q_op_t PI_RDOP = 2'b10;
	localparam pi1q_op_t PI_RWOP = 2'b11;

	// word address, the byte offset bits are dropped
	typedef logic [`PI1Q_ARCHBITSZ - $clog2(`PI1Q_ARCHBITSZ / 8) - 1:0] pi1q_addr_t;

	typedef logic [`PI1Q_ARCHBITSZ - 1:0] pi1q_data_t;

	// one select bit per byte lane of the data word
	typedef logic [`PI1Q_ARCHBITSZ / 8 - 1:0] pi1q_sel_t;

	// index of a master, which is also the index of its queue slot
	typedef logic [$clog2(`PI1Q_MASTERCOUNT) - 1:0] pi1q_midx_t;

	// a complete memory request as seen by the queue and the slave
	typedef struct packed {
		pi1q_op_t   op;
		pi1q_addr_t addr;
		pi1q_data_t data;
		pi1q_sel_t  sel;
	} pi1q_req_t;

endpackage

`default_nettype wire

// File: source/pi1q_params.svh
`ifndef PI1Q_PARAMS_SVH
`define PI1Q_PARAMS_SVH

// number of bus masters sharing the slave
// any value of 2 or more works, the queue holds one slot per master
// more masters means a longer rotation and so more latency per master
`define PI1Q_MASTERCOUNT 3

// width of a data word in bits
// the byte select width and the word address width follow from it
`define PI1Q_ARCHBITSZ 32

// number of word address bits the memory slave decodes
// the slave RAM holds 2 to this power words
`define PI1Q_MEMDEPTH_LOG2 6

// idle cycles the memory slave inserts after every real operation
// zero gives a slave that is ready on every cycle
`define PI1Q_SLAVE_WAIT 2

`endif
